// File: hw/io_port_decoder.sv
// --------------------
// I/O port window decoder
// splits the low address byte into bank select and register index
// --------------------
`timescale 1ns/10ps

module io_port_decoder (
	input  logic [15:0]                            bus_address,
	input  logic                                   bus_read,
	input  logic                                   bus_write,
	input  logic                                   bus_io,
	output logic                                   bus_io_cs,
	output logic [msx_cart_pkg::num_banks-1:0]     bank_read,
	output logic [msx_cart_pkg::num_banks-1:0]     bank_write,
	output logic [msx_cart_pkg::reg_idx_width-1:0] reg_index
);
	import msx_cart_pkg::*;

	localparam int bank_bits   = $clog2(num_banks);
	// low address bits that stay inside the window
	localparam int window_bits = bank_bits + reg_idx_width;

	logic [bank_bits-1:0] bank_sel;
	logic [num_banks-1:0] bank_onehot;

	// Z80 I/O decodes on the low byte only, the upper byte carries B or A
	assign bus_io_cs = (bus_address[7:window_bits] == io_base[7:window_bits]);

	// bank number sits above the register index
	assign bank_sel  = bus_address[window_bits-1:reg_idx_width];
	assign reg_index = bus_address[reg_idx_width-1:0];

	always_comb begin
		bank_onehot           = '0;
		bank_onehot[bank_sel] = 1'b1;
	end

	// fan out only when the cycle is a qualified I/O access
	assign bank_read  = (bus_read && bus_io) ? bank_onehot : '0;
	assign bank_write = (bus_write && bus_io) ? bank_onehot : '0;

endmodule

// File: hw/io_register_bank.sv
// --------------------
// one I/O register bank, three byte registers and a write counter
// answers a read one clock after its strobe
// --------------------
`timescale 1ns/10ps

module io_register_bank (
	input  logic                                   clk,
	input  logic                                   n_reset,
	input  logic                                   bank_read,
	input  logic                                   bank_write,
	input  logic [msx_cart_pkg::reg_idx_width-1:0] reg_index,
	input  logic [7:0]                             write_data,
	output logic                                   bank_ready,
	output logic [7:0]                             bank_rdata
);
	import msx_cart_pkg::*;

	// read/write registers below count_reg
	logic [7:0] reg_q [count_reg];
	logic [7:0] write_count;
	logic       is_count;

	assign is_count = (reg_index == reg_idx_width'(count_reg));

	// data registers, the counter index is read-only
	always_ff @(posedge clk) begin
		if (bank_write && !is_count) begin
			reg_q[reg_index] <= write_data;
		end
	end

	// counts every write to the bank, wraps at 256
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			write_count <= 8'h00;
		end else if (bank_write) begin
			write_count <= write_count + 8'h01;
		end
	end

	// read path
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			bank_ready <= 1'b0;
		end else begin
			bank_ready <= bank_read;
		end
	end

	always_ff @(posedge clk) begin
		if (bank_read) begin
			bank_rdata <= is_count ? write_count : reg_q[reg_index];
		end
	end

endmodule

// File: hw/msx_bus_bridge.sv
// --------------------
// MSX slot bus to internal strobe bus bridge
// syncs and filters the slot strobes, answers host reads from the latched data
// --------------------
`timescale 1ns/10ps

module msx_bus_bridge (
	input  logic        clk,
	input  logic        n_reset,
	// slot side, all asynchronous to clk
	input  logic [15:0] adr,
	input  logic [7:0]  i_data,
	input  logic        n_rd,
	input  logic        n_wr,
	input  logic        n_ioreq,
	output logic [7:0]  o_data,
	output logic        is_output,
	output logic        is_output_d,
	// internal bus
	output logic [15:0] bus_address,
	output logic [7:0]  bus_write_data,
	output logic        bus_read,
	output logic        bus_write,
	output logic        bus_io,
	input  logic        bus_io_cs,
	input  logic        bus_read_ready,
	input  logic [7:0]  bus_read_data
);
	import msx_cart_pkg::*;

	// raw strobe samples, newest in bit 0
	logic [filter_depth-1:0] n_rd_sync;
	logic [filter_depth-1:0] n_wr_sync;
	logic [filter_depth-1:0] n_ioreq_sync;
	// filtered strobes, still active low
	logic                    n_rd_filt;
	logic                    n_wr_filt;
	logic                    n_ioreq_filt;
	// previous filtered level for edge detect
	logic                    n_rd_filt_q;
	logic                    n_wr_filt_q;
	logic                    rd_pulse;
	logic                    wr_pulse;
	// read response hold
	logic [7:0]              read_data_q;
	logic                    read_valid;

	// --------------------
	// sync and low-pass
	// --------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			n_rd_sync    <= '1;
			n_wr_sync    <= '1;
			n_ioreq_sync <= '1;
		end else begin
			n_rd_sync    <= {n_rd_sync[filter_depth-2:0], n_rd};
			n_wr_sync    <= {n_wr_sync[filter_depth-2:0], n_wr};
			n_ioreq_sync <= {n_ioreq_sync[filter_depth-2:0], n_ioreq};
		end
	end

	// active only when the three oldest samples agree on low
	// bit 0 may still be metastable so it stays out of the filter
	assign n_rd_filt    = |n_rd_sync[filter_depth-1 -: 3];
	assign n_wr_filt    = |n_wr_sync[filter_depth-1 -: 3];
	assign n_ioreq_filt = |n_ioreq_sync[filter_depth-1 -: 3];

	// --------------------
	// edge detect
	// --------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			n_rd_filt_q <= 1'b1;
			n_wr_filt_q <= 1'b1;
			bus_read    <= 1'b0;
			bus_write   <= 1'b0;
		end else begin
			n_rd_filt_q <= n_rd_filt;
			n_wr_filt_q <= n_wr_filt;
			// one strobe per falling edge of the filtered level
			bus_read    <= rd_pulse;
			bus_write   <= wr_pulse;
		end
	end

	assign rd_pulse = n_rd_filt_q & ~n_rd_filt;
	assign wr_pulse = n_wr_filt_q & ~n_wr_filt;

	// address and write data line up with the strobe
	always_ff @(posedge clk) begin
		if (rd_pulse || wr_pulse) begin
			bus_address <= adr;
		end
		if (wr_pulse) begin
			bus_write_data <= i_data;
		end
	end

	// I/O qualifier, bus_io_cs is a pure address decode so no loop here
	assign bus_io = ~n_ioreq_filt & bus_io_cs;

	// --------------------
	// slot read response
	// --------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			read_data_q <= 8'h00;
			read_valid  <= 1'b0;
		end else begin
			if (bus_read_ready) begin
				read_data_q <= bus_read_data;
			end
			// set wins over release, the host still holds /RD at this point
			if (bus_read_ready) begin
				read_valid <= 1'b1;
			end else if (n_rd_filt) begin
				read_valid <= 1'b0;
			end
		end
	end

	assign o_data      = read_data_q;
	// raw n_rd drops the driver as soon as the host lets go
	assign is_output   = read_valid & ~n_rd;
	assign is_output_d = read_valid;

endmodule

// File: hw/msx_cart_pkg.sv
// --------------------
// shared constants of the MSX I/O register cartridge
// imported by the RTL and the testbench
// --------------------
package msx_cart_pkg;

	// --------------------
	// bank layout
	// --------------------
	// number of identical register banks behind the port window
	localparam int num_banks = 4;

	// registers per bank, three read/write plus the write counter
	localparam int regs_per_bank = 4;

	// register index width inside one bank
	localparam int reg_idx_width = $clog2(regs_per_bank);

	// index of the read-only write counter
	localparam int count_reg = 3;

	// --------------------
	// slot interface
	// --------------------
	// first I/O port of the window, covers 40h to 4Fh
	localparam logic [7:0] io_base = 8'h40;

	// strobe synchronizer length, the oldest three samples form the filter
	localparam int filter_depth = 4;

endpackage

// File: hw/msx_cart_top.sv
// --------------------
// MSX I/O register cartridge top level
// slot bridge, port decoder, register banks and read collector
// --------------------
`timescale 1ns/10ps

module msx_cart_top (
	input  logic        clk,
	input  logic        n_reset,
	input  logic [15:0] adr,
	input  logic [7:0]  i_data,
	input  logic        n_rd,
	input  logic        n_wr,
	input  logic        n_ioreq,
	output logic [7:0]  o_data,
	output logic        is_output,
	output logic        is_output_d
);
	import msx_cart_pkg::*;

	// --------------------
	// internal bus
	// --------------------
	logic [15:0]                     bus_address;
	logic [7:0]                      bus_write_data;
	logic                            bus_read;
	logic                            bus_write;
	logic                            bus_io;
	logic                            bus_io_cs;
	logic                            bus_read_ready;
	logic [7:0]                      bus_read_data;
	// decoder to banks
	logic [num_banks-1:0]            bank_read;
	logic [num_banks-1:0]            bank_write;
	logic [reg_idx_width-1:0]        reg_index;
	// banks to collector
	logic [num_banks-1:0]            bank_ready;
	logic [num_banks-1:0][7:0]       bank_rdata;

	msx_bus_bridge bridge_i (
		.clk            (clk),
		.n_reset        (n_reset),
		.adr            (adr),
		.i_data         (i_data),
		.n_rd           (n_rd),
		.n_wr           (n_wr),
		.n_ioreq        (n_ioreq),
		.o_data         (o_data),
		.is_output      (is_output),
		.is_output_d    (is_output_d),
		.bus_address    (bus_address),
		.bus_write_data (bus_write_data),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.bus_io         (bus_io),
		.bus_io_cs      (bus_io_cs),
		.bus_read_ready (bus_read_ready),
		.bus_read_data  (bus_read_data)
	);

	io_port_decoder decoder_i (
		.bus_address (bus_address),
		.bus_read    (bus_read),
		.bus_write   (bus_write),
		.bus_io      (bus_io),
		.bus_io_cs   (bus_io_cs),
		.bank_read   (bank_read),
		.bank_write  (bank_write),
		.reg_index   (reg_index)
	);

	// one bank per slice of the port window
	for (genvar bank_gen = 0; bank_gen < num_banks; bank_gen++) begin : g_bank
		io_register_bank bank_i (
			.clk        (clk),
			.n_reset    (n_reset),
			.bank_read  (bank_read[bank_gen]),
			.bank_write (bank_write[bank_gen]),
			.reg_index  (reg_index),
			.write_data (bus_write_data),
			.bank_ready (bank_ready[bank_gen]),
			.bank_rdata (bank_rdata[bank_gen])
		);
	end

	read_data_collector collector_i (
		.clk            (clk),
		.n_reset        (n_reset),
		.bank_ready     (bank_ready),
		.bank_rdata     (bank_rdata),
		.bus_read_ready (bus_read_ready),
		.bus_read_data  (bus_read_data)
	);

endmodule

// File: hw/read_data_collector.sv
// --------------------
// merges the bank read responses into one registered reply
// at most one bank answers per read cycle
// --------------------
`timescale 1ns/10ps

module read_data_collector (
	input  logic                                     clk,
	input  logic                                     n_reset,
	input  logic [msx_cart_pkg::num_banks-1:0]       bank_ready,
	input  logic [msx_cart_pkg::num_banks-1:0][7:0]  bank_rdata,
	output logic                                     bus_read_ready,
	output logic [7:0]                               bus_read_data
);
	import msx_cart_pkg::*;

	logic [7:0] sel_data;

	// pick the answering bank, idle banks may hold stale data
	always_comb begin
		sel_data = 8'h00;
		for (int i = 0; i < num_banks; i++) begin
			if (bank_ready[i]) begin
				sel_data = bank_rdata[i];
			end
		end
	end

	// response stage toward the bridge
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			bus_read_ready <= 1'b0;
		end else begin
			bus_read_ready <= |bank_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (|bank_ready) begin
			bus_read_data <= sel_data;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the cartridge testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_msx_cart \
	-f vlog.f -Mdir obj_dir -o sim_msx_cart > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status, see build.log"
	exit 1
fi

./obj_dir/sim_msx_cart > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^No errors$" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// File: sim/msx_cart_checker.sv
// --------------------
// assertions on the bridge strobes and slot response
// attached to every bridge instance with bind
// --------------------
`timescale 1ns/10ps

module msx_cart_checker (
	input logic clk,
	input logic n_reset,
	input logic bus_read,
	input logic bus_write,
	input logic is_output,
	input logic n_rd
);

	// read and write strobes are exclusive
	assert property (@(posedge clk) disable iff (!n_reset) !(bus_read && bus_write))
		else $error("bus_read and bus_write high together");

	// each strobe is a single clock wide
	assert property (@(posedge clk) disable iff (!n_reset) bus_read |=> !bus_read)
		else $error("bus_read longer than one clock");

	assert property (@(posedge clk) disable iff (!n_reset) bus_write |=> !bus_write)
		else $error("bus_write longer than one clock");

	// slot driver only turns on once the host already holds /RD low
	assert property (@(posedge clk) disable iff (!n_reset) $rose(is_output) |-> $past(!n_rd))
		else $error("is_output rose while n_rd was high");

endmodule

bind msx_bus_bridge msx_cart_checker checker_i (
	.clk       (clk),
	.n_reset   (n_reset),
	.bus_read  (bus_read),
	.bus_write (bus_write),
	.is_output (is_output),
	.n_rd      (n_rd)
);

// File: sim/msx_cart_stimulus.txt
# columns: op port data, all hex; W writes data to port, R expects data from port
# U reads a port outside 40-4F that must not answer, its data column is ignored
W 40 a5
R 40 a5
W 41 3c
W 42 f0
R 41 3c
R 42 f0
W 44 11
W 48 22
W 4c 33
W 40 99
R 40 99
R 44 11
R 48 22
R 4c 33
W 4d 5a
W 4f 77
W 50 12
U 50 00
U 3f 00
R 43 04
R 47 01
R 4b 01
R 4f 03
R 4d 5a

// File: sim/tb_msx_cart.sv
// --------------------
// testbench for the MSX I/O register cartridge, replays slot cycles from the stimulus file
// writes registers, reads them back and checks counters, unmapped ports and release timing
// --------------------
`timescale 1ns/10ps

module tb_msx_cart;
	import msx_cart_pkg::*;

	// wait limits in clocks
	localparam int read_timeout    = 20;
	localparam int release_timeout = 5;
	// ports covered by the cartridge window
	localparam int window_size     = num_banks * regs_per_bank;

	logic        clk;
	logic        n_reset;
	logic [15:0] adr;
	logic [7:0]  i_data;
	logic        n_rd;
	logic        n_wr;
	logic        n_ioreq;
	logic [7:0]  o_data;
	logic        is_output;
	logic        is_output_d;

	// bookkeeping
	int          checks;
	int          value_errors;
	int          other_errors;
	logic [7:0]  lfsr_state;

	msx_cart_top dut_i (
		.clk         (clk),
		.n_reset     (n_reset),
		.adr         (adr),
		.i_data      (i_data),
		.n_rd        (n_rd),
		.n_wr        (n_wr),
		.n_ioreq     (n_ioreq),
		.o_data      (o_data),
		.is_output   (is_output),
		.is_output_d (is_output_d)
	);

	// 40 ns clock
	always #20 clk = ~clk;

	// --------------------
	// helpers
	// --------------------
	// 8-bit Fibonacci LFSR, taps 8 6 5 4
	function automatic logic [7:0] lfsr_step(input logic [7:0] state);
		logic feedback;
		feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
		return {state[6:0], feedback};
	endfunction

	task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
		input string msg);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
		end
	endtask

	// idle of 2 to 9 clocks, three LFSR bits per gap
	task automatic idle_gap();
		logic [2:0] bits;
		bits = '0;
		for (int i = 0; i < 3; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			bits       = {bits[1:0], lfsr_state[0]};
		end
		repeat (32'(bits) + 2) @(negedge clk);
	endtask

	// host I/O write, strobes held for 10 clocks
	task automatic slot_write(input logic [7:0] port, input logic [7:0] data);
		adr     = {8'h00, port};
		i_data  = data;
		n_ioreq = 1'b0;
		n_wr    = 1'b0;
		repeat (10) @(negedge clk);
		n_wr    = 1'b1;
		n_ioreq = 1'b1;
	endtask

	// is_output_d has to drop shortly after /RD goes high
	task automatic wait_release(input logic [7:0] port);
		int cycles;
		cycles = 0;
		while (is_output_d && cycles < release_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (is_output_d) begin
			other_errors++;
			$display("timeout at %0t ns: is_output_d still high after read of port %h",
				$time, port);
		end
	endtask

	// host I/O read, mapped ports must answer, unmapped ones must stay silent
	task automatic slot_read(input logic [7:0] port, input logic [7:0] expected,
		input logic mapped);
		int   cycles;
		logic seen;
		cycles  = 0;
		seen    = 1'b0;
		adr     = {8'h00, port};
		n_ioreq = 1'b0;
		n_rd    = 1'b0;
		// outputs settle mid cycle, sample on the falling edge
		while (!seen && cycles < read_timeout) begin
			@(negedge clk);
			cycles++;
			seen = is_output;
		end
		if (!mapped) begin
			check_value(16'(seen), 16'h0000, $sformatf("unmapped port %h answered", port));
		end else if (seen) begin
			check_value(16'(o_data), 16'(expected), $sformatf("read of port %h", port));
		end else begin
			other_errors++;
			$display("timeout at %0t ns: no is_output for read of port %h", $time, port);
		end
		n_rd    = 1'b1;
		n_ioreq = 1'b1;
		// driver follows raw /RD without a clock
		#1;
		check_value(16'(is_output), 16'h0000, $sformatf("is_output after release of %h", port));
		wait_release(port);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		int         fd;
		int         fields;
		string      line;
		logic [7:0] op;
		logic [7:0] port;
		logic [7:0] data;
		logic       in_window;
		clk          = 1'b0;
		n_reset      = 1'b0;
		adr          = 16'h0000;
		i_data       = 8'h00;
		n_rd         = 1'b1;
		n_wr         = 1'b1;
		n_ioreq      = 1'b1;
		checks       = 0;
		value_errors = 0;
		other_errors = 0;
		lfsr_state   = 8'd89;
		repeat (3) @(negedge clk);
		n_reset = 1'b1;
		@(negedge clk);
		// slot side idle after reset
		check_value(16'(is_output), 16'h0000, "is_output after reset");
		check_value(16'(is_output_d), 16'h0000, "is_output_d after reset");
		check_value(16'(o_data), 16'h0000, "o_data after reset");

		fd = $fopen("sim/msx_cart_stimulus.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open the stimulus file sim/msx_cart_stimulus.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				// skip blank and comment lines
				if (line.len() > 1 && line[0] != "#") begin
					fields    = $sscanf(line, "%c %h %h", op, port, data);
					in_window = 32'(port) >= 32'(io_base) &&
						32'(port) < 32'(io_base) + window_size;
					if (fields != 3) begin
						other_errors++;
						$display("unreadable stimulus line: %s", line);
					end else if (op == "W") begin
						slot_write(port, data);
					end else if (op == "R") begin
						slot_read(port, data, 1'b1);
					end else if (op == "U") begin
						if (in_window) begin
							other_errors++;
							$display("stimulus marks port %h unmapped but it is in the window", port);
						end
						slot_read(port, 8'h00, 1'b0);
					end else begin
						other_errors++;
						$display("unknown operation in stimulus line: %s", line);
					end
					idle_gap();
				end
			end
			$fclose(fd);
		end

		$display("checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: vlog.f
hw/msx_cart_pkg.sv
hw/msx_bus_bridge.sv
hw/io_port_decoder.sv
hw/io_register_bank.sv
hw/read_data_collector.sv
hw/msx_cart_top.sv
sim/msx_cart_checker.sv
sim/tb_msx_cart.sv
